/* hdl/systolic_cfg.svh */
`ifndef SYSTOLIC_CFG_SVH
`define SYSTOLIC_CFG_SVH

// Array geometry, square DIM x DIM grid
`define SYS_DIM 4

// Signed activation and weight bytes
`define SYS_DATA_W 8

// Partial sums wrap at this width
`define SYS_ACC_W 20

// Accumulator buffer rows and address width
`define SYS_ACC_DEPTH 16
`define SYS_ADDR_W 4

// Configuration register address width
`define SYS_REG_ADDR_W 6

// Edges from activation strobe to buffer write
`define SYS_LATENCY (2 * `SYS_DIM)

`endif

/* hdl/systolic_pkg.sv */
`include "systolic_cfg.svh"

package systolic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    // One activation or weight byte
    typedef logic signed [`SYS_DATA_W-1:0] data_t;
    // One partial sum
    typedef logic signed [`SYS_ACC_W-1:0] psum_t;

    // Full rows, lane 0 in the low bits
    typedef data_t [`SYS_DIM-1:0] act_row_t;
    typedef psum_t [`SYS_DIM-1:0] psum_row_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Bit 0 selects accumulate
    localparam logic [`SYS_REG_ADDR_W-1:0] REG_CTRL    = 'd0;
    // Destination base row
    localparam logic [`SYS_REG_ADDR_W-1:0] REG_BASE    = 'd1;
    // Weight k,n at REG_WEIGHT0 + k*DIM + n
    localparam logic [`SYS_REG_ADDR_W-1:0] REG_WEIGHT0 = 'd16;

endpackage

/* hdl/skew_line.sv */
`timescale 1ns/1ps

module skew_line #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  T     din,
    output T     dout
);

    if (DEPTH == 0) begin : g_pass
        // Zero delay lane, straight through
        assign dout = din;
    end else begin : g_chain
        // Register chain, stage 0 nearest the input
        T stages [DEPTH];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                // Skewed lanes start from zero
                for (int i = 0; i < DEPTH; i++) begin
                    stages[i] <= '0;
                end
            end else begin
                stages[0] <= din;
                // Shift one stage per cycle
                for (int i = 1; i < DEPTH; i++) begin
                    stages[i] <= stages[i-1];
                end
            end
        end

        assign dout = stages[DEPTH-1];
    end

endmodule

/* hdl/mac_cell.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module mac_cell (
    input  logic                clk,
    input  logic                rst_n,
    // Stationary weight for this cell
    input  systolic_pkg::data_t weight,
    // Activation from the left neighbour
    input  systolic_pkg::data_t act_in,
    // Partial sum from the cell above
    input  systolic_pkg::psum_t psum_in,
    // Activation to the right neighbour
    output systolic_pkg::data_t act_out,
    // Partial sum to the cell below
    output systolic_pkg::psum_t psum_out
);

    ////////////////////////////////////////////////////////////////////////////
    // Multiply
    ////////////////////////////////////////////////////////////////////////////

    // Product sized to the sum width, signed extension of both bytes
    systolic_pkg::psum_t prod;

    assign prod = act_in * weight;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out  <= '0;
            psum_out <= '0;
        end else begin
            // Pass activation right unchanged
            act_out  <= act_in;
            // Add this row's term, wraps at SYS_ACC_W
            psum_out <= psum_in + prod;
        end
    end

endmodule

/* hdl/systolic_array.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module systolic_array (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         act_valid,
    input  systolic_pkg::act_row_t                       act_row,
    // Flattened weight matrix, index k*DIM + n
    input  systolic_pkg::data_t [`SYS_DIM*`SYS_DIM-1:0] weights,
    output logic                                         out_valid,
    output systolic_pkg::psum_row_t                      out_row,
    output logic                                         busy
);

    localparam int DIM = `SYS_DIM;
    localparam int LAT = `SYS_LATENCY;

    // Captured input row, zero when no strobe
    systolic_pkg::act_row_t act_q;
    // One bit per row in flight, bit 0 holds the current input
    logic [LAT-1:0]         valid_sr;

    // Activation into cell k,n
    systolic_pkg::data_t act_h [DIM][DIM];
    // Partial sum into row k of column n, row DIM is the bottom edge
    systolic_pkg::psum_t psum_v [DIM+1][DIM];
    // Deskewed column sums
    systolic_pkg::psum_t psum_d [DIM];

    ////////////////////////////////////////////////////////////////////////////
    // Input capture and valid tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q    <= '0;
            valid_sr <= '0;
        end else begin
            act_q    <= act_valid ? act_row : '0;
            valid_sr <= {valid_sr[LAT-2:0], act_valid};
        end
    end

    // Last stage lines up with the deskewed row
    assign out_valid = valid_sr[LAT-1];
    assign busy      = |valid_sr;

    ////////////////////////////////////////////////////////////////////////////
    // Input skew, lane k late by k cycles
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < DIM; k++) begin : g_in_skew
        skew_line #(
            .T     (systolic_pkg::data_t),
            .DEPTH (k)
        ) u_skew (
            .clk   (clk),
            .rst_n (rst_n),
            .din   (act_q[k]),
            .dout  (act_h[k][0])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cell grid
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < DIM; k++) begin : g_row
        for (genvar n = 0; n < DIM; n++) begin : g_col
            if (k == 0) begin : g_top
                // Columns start from a zero sum
                assign psum_v[0][n] = '0;
            end
            if (n < DIM - 1) begin : g_inner
                mac_cell u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .weight   (weights[k*DIM+n]),
                    .act_in   (act_h[k][n]),
                    .psum_in  (psum_v[k][n]),
                    .act_out  (act_h[k][n+1]),
                    .psum_out (psum_v[k+1][n])
                );
            end else begin : g_east
                // Rightmost column, activation stops here
                mac_cell u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .weight   (weights[k*DIM+n]),
                    .act_in   (act_h[k][n]),
                    .psum_in  (psum_v[k][n]),
                    .act_out  (),
                    .psum_out (psum_v[k+1][n])
                );
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output deskew, column n late by DIM-1-n cycles
    ////////////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < DIM; n++) begin : g_out_skew
        skew_line #(
            .T     (systolic_pkg::psum_t),
            .DEPTH (DIM - 1 - n)
        ) u_deskew (
            .clk   (clk),
            .rst_n (rst_n),
            .din   (psum_v[DIM][n]),
            .dout  (psum_d[n])
        );
    end

    // Pack columns into the output row
    always_comb begin
        for (int n = 0; n < DIM; n++) begin
            out_row[n] = psum_d[n];
        end
    end

endmodule

/* hdl/mm_regs.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module mm_regs (
    input  logic                                         clk,
    input  logic                                         rst_n,
    // Register write port
    input  logic                                         reg_wr,
    input  logic [`SYS_REG_ADDR_W-1:0]                   reg_addr,
    input  logic [31:0]                                  reg_wdata,
    // One pulse per row written to the buffer
    input  logic                                         row_done,
    // Flattened weight matrix, index k*DIM + n
    output systolic_pkg::data_t [`SYS_DIM*`SYS_DIM-1:0] weights,
    output logic                                         acc_en,
    output logic [`SYS_ADDR_W-1:0]                       wr_addr
);

    localparam int NUM_W = `SYS_DIM * `SYS_DIM;

    // Offset from the first weight register
    logic [`SYS_REG_ADDR_W-1:0] w_idx;
    // Address decode
    logic                       hit_ctrl;
    logic                       hit_base;
    logic                       hit_weight;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign w_idx      = reg_addr - systolic_pkg::REG_WEIGHT0;
    assign hit_ctrl   = reg_wr && (reg_addr == systolic_pkg::REG_CTRL);
    assign hit_base   = reg_wr && (reg_addr == systolic_pkg::REG_BASE);
    // Weight window, NUM_W words from REG_WEIGHT0
    assign hit_weight = reg_wr && (reg_addr >= systolic_pkg::REG_WEIGHT0) &&
                        (w_idx < NUM_W);

    ////////////////////////////////////////////////////////////////////////////
    // Weight storage and mode bit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '0;
            acc_en  <= 1'b0;
        end else begin
            if (hit_weight) begin
                // Low byte only, upper bits ignored
                weights[w_idx] <= reg_wdata[`SYS_DATA_W-1:0];
            end
            if (hit_ctrl) begin
                acc_en <= reg_wdata[0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Destination row counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (hit_base) begin
            // Base write wins over a finishing row
            wr_addr <= reg_wdata[`SYS_ADDR_W-1:0];
        end else if (row_done) begin
            // Step and wrap at buffer depth
            if (wr_addr == `SYS_ADDR_W'(`SYS_ACC_DEPTH - 1)) begin
                wr_addr <= '0;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

/* hdl/accumulator.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module accumulator (
    input  logic                         clk,
    // Write side, one psum row per strobe
    input  logic                         wea,
    input  logic                         acc_en,
    input  logic [`SYS_ADDR_W-1:0]       addra,
    input  systolic_pkg::psum_row_t      dina,
    // Read side, one cycle latency
    input  logic                         enb,
    input  logic [`SYS_ADDR_W-1:0]       addrb,
    output systolic_pkg::psum_row_t      doutb
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Row buffer, contents undefined until first overwrite
    systolic_pkg::psum_row_t mem [`SYS_ACC_DEPTH];

    // Old row plus incoming row
    systolic_pkg::psum_row_t sum_row;

    ////////////////////////////////////////////////////////////////////////////
    // Lane-wise add
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `SYS_DIM; i++) begin
            // Each lane wraps on its own, no carry across lanes
            sum_row[i] = mem[addra][i] + dina[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write and read ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wea) begin
            // Accumulate or overwrite
            mem[addra] <= acc_en ? sum_row : dina;
        end
    end

    always_ff @(posedge clk) begin
        // Same-address read during write returns the old row
        if (enb) begin
            doutb <= mem[addrb];
        end
    end

endmodule

/* hdl/systolic_top.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module systolic_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // Configuration writes
    input  logic                         reg_wr,
    input  logic [`SYS_REG_ADDR_W-1:0]   reg_addr,
    input  logic [31:0]                  reg_wdata,
    // Activation rows, no back-pressure
    input  logic                         act_valid,
    input  systolic_pkg::act_row_t       act_row,
    // Result readback
    input  logic                         rd_en,
    input  logic [`SYS_ADDR_W-1:0]       rd_addr,
    output systolic_pkg::psum_row_t      rd_data,
    // Rows still in the array
    output logic                         busy
);

    // Config to array and buffer
    systolic_pkg::data_t [`SYS_DIM*`SYS_DIM-1:0] weights;
    logic                                         acc_en;
    logic [`SYS_ADDR_W-1:0]                       wr_addr;
    // Array to buffer
    logic                                         out_valid;
    systolic_pkg::psum_row_t                      out_row;

    mm_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        // Counter steps on every buffer write
        .row_done  (out_valid),
        .weights   (weights),
        .acc_en    (acc_en),
        .wr_addr   (wr_addr)
    );

    systolic_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_valid (act_valid),
        .act_row   (act_row),
        .weights   (weights),
        .out_valid (out_valid),
        .out_row   (out_row),
        .busy      (busy)
    );

    accumulator u_acc (
        .clk    (clk),
        .wea    (out_valid),
        .acc_en (acc_en),
        .addra  (wr_addr),
        .dina   (out_row),
        .enb    (rd_en),
        .addrb  (rd_addr),
        .doutb  (rd_data)
    );

endmodule

/* dv/tb_systolic_model.svh */
`ifndef TB_SYSTOLIC_MODEL_SVH
`define TB_SYSTOLIC_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////////////////////

// Galois LFSR state, seed 3
logic [15:0] lfsr_state = 16'd3;

// Weights as the register port wrote them, zero after reset
systolic_pkg::data_t model_w [`SYS_DIM][`SYS_DIM] = '{default: '0};
logic                model_acc  = 1'b0;
// Expected destination row counter
int                  model_addr = 0;

// Expected buffer contents, valid only where shadow_set is high
systolic_pkg::psum_row_t shadow [`SYS_ACC_DEPTH];
bit                      shadow_set [`SYS_ACC_DEPTH] = '{default: 1'b0};

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

// One LFSR step per bit, taps 0xB400
function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        val = {val[30:0], out_bit};
    end
    return val;
endfunction

////////////////////////////////////////////////////////////////////////////
// Register and row rules
////////////////////////////////////////////////////////////////////////////

function automatic void model_reg_write(input logic [`SYS_REG_ADDR_W-1:0] addr,
                                        input logic [31:0] data);
    int idx;
    idx = int'(addr) - int'(systolic_pkg::REG_WEIGHT0);
    if (addr == systolic_pkg::REG_CTRL) begin
        model_acc = data[0];
    end else if (addr == systolic_pkg::REG_BASE) begin
        // Counter restarts at the written row
        model_addr = int'(data % `SYS_ACC_DEPTH);
    end else if (idx >= 0 && idx < `SYS_DIM * `SYS_DIM) begin
        model_w[idx / `SYS_DIM][idx % `SYS_DIM] = data[`SYS_DATA_W-1:0];
    end
endfunction

// Column n = sum over k of act[k] * w[k][n], wrapped to SYS_ACC_W
function automatic systolic_pkg::psum_row_t row_product(input systolic_pkg::act_row_t row);
    systolic_pkg::psum_row_t prod;
    systolic_pkg::data_t     a;
    systolic_pkg::data_t     w;
    int                      acc;
    for (int n = 0; n < `SYS_DIM; n++) begin
        acc = 0;
        for (int k = 0; k < `SYS_DIM; k++) begin
            a   = row[k];
            w   = model_w[k][n];
            acc = acc + int'(a) * int'(w);
        end
        prod[n] = systolic_pkg::psum_t'(acc);
    end
    return prod;
endfunction

// Overwrite or lane-wise add at the counter, then step it
function automatic void model_apply_row(input systolic_pkg::act_row_t row);
    systolic_pkg::psum_row_t prod;
    systolic_pkg::psum_t     old_lane;
    systolic_pkg::psum_t     new_lane;
    prod = row_product(row);
    if (model_acc) begin
        for (int n = 0; n < `SYS_DIM; n++) begin
            old_lane = shadow[model_addr][n];
            new_lane = prod[n];
            shadow[model_addr][n] = systolic_pkg::psum_t'(int'(old_lane) + int'(new_lane));
        end
    end else begin
        shadow[model_addr]     = prod;
        shadow_set[model_addr] = 1'b1;
    end
    model_addr = (model_addr + 1) % `SYS_ACC_DEPTH;
endfunction

`endif

/* dv/tb_systolic_top.sv */
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module tb_systolic_top;

    localparam int DIM          = `SYS_DIM;
    localparam int LAT          = `SYS_LATENCY;
    localparam int DEPTH        = `SYS_ACC_DEPTH;
    // Bounds for the waits
    localparam int IDLE_TIMEOUT = 4 * LAT;
    localparam int RD_LAT       = 1;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           reg_wr;
    logic [`SYS_REG_ADDR_W-1:0]     reg_addr;
    logic [31:0]                    reg_wdata;
    logic                           act_valid;
    systolic_pkg::act_row_t         act_row;
    logic                           rd_en;
    logic [`SYS_ADDR_W-1:0]         rd_addr;
    systolic_pkg::psum_row_t        rd_data;
    logic                           busy;

    int err_mismatch = 0;
    int err_timeout  = 0;
    int err_other    = 0;

    `include "tb_systolic_model.svh"

    systolic_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .act_valid (act_valid),
        .act_row   (act_row),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    task automatic finish_run();
        $display("errors: mismatches %0d, timeouts %0d, other %0d",
                 err_mismatch, err_timeout, err_other);
        if (err_mismatch + err_timeout + err_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers, all start and end on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic reg_write(input logic [`SYS_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        model_reg_write(addr, data);
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    // One row per call, calls in a row give back-to-back strobes
    task automatic send_row(input systolic_pkg::act_row_t row);
        act_valid = 1'b1;
        act_row   = row;
        model_apply_row(row);
        @(negedge clk);
        act_valid = 1'b0;
        act_row   = '0;
    endtask

    function automatic systolic_pkg::act_row_t random_row();
        systolic_pkg::act_row_t row;
        for (int k = 0; k < DIM; k++) begin
            row[k] = rand_bits(`SYS_DATA_W);
        end
        return row;
    endfunction

    task automatic load_weights(input bit use_random, input logic [7:0] fixed);
        for (int idx = 0; idx < DIM * DIM; idx++) begin
            reg_write(systolic_pkg::REG_WEIGHT0 + `SYS_REG_ADDR_W'(idx),
                      use_random ? rand_bits(`SYS_DATA_W) : 32'(fixed));
        end
    endtask

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while (busy && cnt < IDLE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (busy) begin
            err_timeout++;
            $display("timeout: busy still high %0d cycles after %s", IDLE_TIMEOUT, what);
            finish_run();
        end
    endtask

    // Read one row and compare with the shadow
    task automatic read_check(input int row_idx);
        rd_en   = 1'b1;
        rd_addr = `SYS_ADDR_W'(row_idx);
        for (int i = 0; i < RD_LAT; i++) begin
            @(negedge clk);
        end
        rd_en   = 1'b0;
        if (!shadow_set[row_idx]) begin
            err_other++;
            $display("read of row %0d, which was never overwritten", row_idx);
        end else begin
            assert (rd_data === shadow[row_idx]) else begin
                err_mismatch++;
                $display("mismatch rd_data row %0d: got %h expected %h",
                         row_idx, rd_data, shadow[row_idx]);
            end
        end
    endtask

    // Read held open on the row while one isolated row flies
    task automatic check_latency(input int row_idx);
        systolic_pkg::psum_row_t old_row;
        old_row = shadow[row_idx];
        reg_write(systolic_pkg::REG_BASE, 32'(row_idx));
        rd_en   = 1'b1;
        rd_addr = `SYS_ADDR_W'(row_idx);
        send_row(random_row());
        if (shadow[row_idx] === old_row) begin
            err_other++;
            $display("latency row product equals the old contents, change not visible");
        end
        // rd_data now holds the capture from the strobe edge, cycle 0
        for (int cyc = 0; cyc <= LAT + 1; cyc++) begin
            if (cyc > 0) begin
                @(negedge clk);
            end
            assert (busy === (cyc < LAT)) else begin
                err_mismatch++;
                $display("mismatch busy cycle %0d: got %h expected %h", cyc, busy, cyc < LAT);
            end
            // Write lands on edge LAT, read register shows it one edge later
            assert (rd_data === ((cyc <= LAT) ? old_row : shadow[row_idx])) else begin
                err_mismatch++;
                $display("mismatch rd_data cycle %0d: got %h expected %h", cyc, rd_data,
                         (cyc <= LAT) ? old_row : shadow[row_idx]);
            end
        end
        rd_en = 1'b0;
        wait_idle("latency row");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        act_valid = 1'b0;
        act_row   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;

        // Idle out of reset
        assert (busy === 1'b0) else begin
            err_mismatch++;
            $display("mismatch busy after reset: got %h expected %h", busy, 1'b0);
        end

        // Overwrite, four back-to-back rows from base 0
        load_weights(1'b1, 8'h00);
        reg_write(systolic_pkg::REG_CTRL, 32'd0);
        reg_write(systolic_pkg::REG_BASE, 32'd0);
        for (int j = 0; j < 4; j++) begin
            send_row(random_row());
        end
        wait_idle("overwrite rows");
        for (int j = 0; j < 4; j++) begin
            read_check(j);
        end

        // Accumulate onto the same four rows
        reg_write(systolic_pkg::REG_CTRL, 32'd1);
        reg_write(systolic_pkg::REG_BASE, 32'd0);
        for (int j = 0; j < 4; j++) begin
            send_row(random_row());
        end
        wait_idle("accumulate rows");
        for (int j = 0; j < 4; j++) begin
            read_check(j);
        end

        // Counter wraps past the last row
        reg_write(systolic_pkg::REG_CTRL, 32'd0);
        reg_write(systolic_pkg::REG_BASE, 32'd14);
        for (int j = 0; j < 4; j++) begin
            send_row(random_row());
        end
        wait_idle("wrapping rows");
        for (int j = 0; j < 4; j++) begin
            read_check((14 + j) % DEPTH);
        end
        read_check(2);
        read_check(3);

        // Zero row gives a known old value at row 5
        reg_write(systolic_pkg::REG_BASE, 32'd5);
        send_row('0);
        wait_idle("zero row");
        check_latency(5);

        // Extreme values, each add is 4 * 16384, wraps on the 8th
        load_weights(1'b0, 8'h80);
        reg_write(systolic_pkg::REG_BASE, 32'd9);
        send_row({`SYS_DIM{8'h80}});
        wait_idle("overflow seed row");
        read_check(9);
        reg_write(systolic_pkg::REG_CTRL, 32'd1);
        for (int rep = 0; rep < 9; rep++) begin
            reg_write(systolic_pkg::REG_BASE, 32'd9);
            send_row({`SYS_DIM{8'h80}});
            wait_idle("overflow row");
            read_check(9);
        end

        finish_run();
    end

endmodule

/* systolic_mm.f */
+incdir+hdl
+incdir+dv
hdl/systolic_pkg.sv
hdl/skew_line.sv
hdl/mac_cell.sv
hdl/systolic_array.sv
hdl/mm_regs.sv
hdl/accumulator.sv
hdl/systolic_top.sv
dv/tb_systolic_top.sv

/* Bender.yml */
package:
  name: systolic_mm

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/systolic_pkg.sv
      - hdl/skew_line.sv
      - hdl/mac_cell.sv
      - hdl/systolic_array.sv
      - hdl/mm_regs.sv
      - hdl/accumulator.sv
      - hdl/systolic_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - dv
    files:
      - dv/tb_systolic_top.sv
